// File: hdl/merge_pkg.sv
package merge_pkg;

   // Default record geometry. The low KEY_W bits of a record are its key.
   localparam int DATA_W  = 32;
   localparam int KEY_W   = 16;
   localparam int TUPLE_E = 4;

   typedef logic [DATA_W-1:0]         record_t;
   typedef logic [TUPLE_E*DATA_W-1:0] tuple_t;

   typedef enum logic [1:0] {
      SEL_FIRST = 2'd0,
      SEL_RUN   = 2'd1,
      SEL_FLUSH = 2'd2
   } select_state_t;

   typedef enum logic {
      EMIT_MERGE = 1'b0,
      EMIT_TERM  = 1'b1
   } emit_state_t;

endpackage

// File: hdl/merge_issue_if.sv
`timescale 1ns/10ps

interface merge_issue_if #(
   parameter int P_DATA_W  = merge_pkg::DATA_W,
   parameter int P_TUPLE_E = merge_pkg::TUPLE_E
) ();

   // One-cycle strobe, never held.
   logic                          valid;
   logic [P_TUPLE_E*P_DATA_W-1:0] tuple;
   // Opening tuple of a run.
   logic                          first;
   // Both runs ended, no tuple attached.
   logic                          flush;

   modport sel (
      output valid,
      output tuple,
      output first,
      output flush
   );

   modport net (
      input valid,
      input tuple,
      input first,
      input flush
   );

endinterface

// File: hdl/merge_select.sv
`timescale 1ns/10ps

module merge_select #(
   parameter int P_DATA_W  = merge_pkg::DATA_W,
   parameter int P_KEY_W   = merge_pkg::KEY_W,
   parameter int P_TUPLE_E = merge_pkg::TUPLE_E
) (
   input  logic                          i_clk,
   input  logic                          i_rst_n,
   input  logic [P_TUPLE_E*P_DATA_W-1:0] i_a_data,
   input  logic [P_TUPLE_E*P_DATA_W-1:0] i_b_data,
   input  logic                          i_a_empty,
   input  logic                          i_b_empty,
   input  logic                          i_room,
   output logic                          o_a_read,
   output logic                          o_b_read,
   merge_issue_if.sel                    issue
);
   import merge_pkg::*;

   select_state_t     state;
   logic              a_term;
   logic              b_term;
   logic [P_KEY_W-1:0] a_key;
   logic [P_KEY_W-1:0] b_key;
   logic              can_pick;
   logic              take_a;
   logic              take_b;
   logic              end_runs;

   // A zero smallest record marks a terminator tuple.
   assign a_term = (i_a_data[P_DATA_W-1:0] == '0);
   assign b_term = (i_b_data[P_DATA_W-1:0] == '0);
   assign a_key  = i_a_data[P_KEY_W-1:0];
   assign b_key  = i_b_data[P_KEY_W-1:0];

   // Both heads are needed before any choice can be made.
   assign can_pick = i_room && (state != SEL_FLUSH) && !i_a_empty && !i_b_empty;
   assign end_runs = can_pick && a_term && b_term;
   assign take_a   = can_pick && !a_term && (b_term || (a_key <= b_key));
   assign take_b   = can_pick && !b_term && (a_term || (a_key > b_key));

   assign o_a_read = take_a || end_runs;
   assign o_b_read = take_b || end_runs;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state       <= SEL_FIRST;
         issue.valid <= 1'b0;
         issue.first <= 1'b0;
         issue.flush <= 1'b0;
      end else begin
         issue.valid <= take_a || take_b || end_runs;
         issue.first <= (state == SEL_FIRST);
         issue.flush <= end_runs;
         case (state)
            SEL_FIRST: begin
               if (end_runs) begin
                  state <= SEL_FLUSH;
               end else if (take_a || take_b) begin
                  state <= SEL_RUN;
               end
            end
            SEL_RUN: begin
               if (end_runs) begin
                  state <= SEL_FLUSH;
               end
            end
            // Flush is on the interface this cycle.
            SEL_FLUSH: state <= SEL_FIRST;
            default:   state <= SEL_FIRST;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (take_a) begin
         issue.tuple <= i_a_data;
      end else if (take_b) begin
         issue.tuple <= i_b_data;
      end
   end

endmodule

// File: hdl/bitonic_merge.sv
`timescale 1ns/10ps

module bitonic_merge #(
   parameter int P_DATA_W  = merge_pkg::DATA_W,
   parameter int P_KEY_W   = merge_pkg::KEY_W,
   parameter int P_TUPLE_E = merge_pkg::TUPLE_E
) (
   input  logic                          i_clk,
   input  logic                          i_rst_n,
   merge_issue_if.net                    issue,
   output logic                          o_wr,
   output logic [P_TUPLE_E*P_DATA_W-1:0] o_wr_tuple
);
   import merge_pkg::*;

   localparam int LANES  = 2 * P_TUPLE_E;
   localparam int LAYERS = $clog2(LANES);

   emit_state_t                   state;
   logic [P_TUPLE_E*P_DATA_W-1:0] carry;
   logic [P_TUPLE_E*P_DATA_W-1:0] merged_low;
   logic [P_TUPLE_E*P_DATA_W-1:0] merged_high;
   logic [P_DATA_W-1:0]           lane [0:LAYERS][0:LANES-1];

   // Carry ascending in the low lanes, new tuple reversed above it.
   for (genvar i = 0; i < P_TUPLE_E; i++) begin : g_load
      assign lane[0][i]             = carry[i*P_DATA_W +: P_DATA_W];
      assign lane[0][P_TUPLE_E + i] = issue.tuple[(P_TUPLE_E-1-i)*P_DATA_W +: P_DATA_W];
   end

   // Half-cleaner layers, distance E down to 1.
   for (genvar l = 0; l < LAYERS; l++) begin : g_layer
      localparam int D = P_TUPLE_E >> l;
      for (genvar j = 0; j < LANES; j++) begin : g_lane
         if (((j / D) % 2) == 0) begin : g_min
            assign lane[l+1][j] =
               (lane[l][j][P_KEY_W-1:0] > lane[l][j+D][P_KEY_W-1:0]) ?
               lane[l][j+D] : lane[l][j];
         end else begin : g_max
            assign lane[l+1][j] =
               (lane[l][j-D][P_KEY_W-1:0] > lane[l][j][P_KEY_W-1:0]) ?
               lane[l][j-D] : lane[l][j];
         end
      end
   end

   for (genvar i = 0; i < P_TUPLE_E; i++) begin : g_unload
      assign merged_low[i*P_DATA_W +: P_DATA_W]  = lane[LAYERS][i];
      assign merged_high[i*P_DATA_W +: P_DATA_W] = lane[LAYERS][P_TUPLE_E + i];
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= EMIT_MERGE;
         o_wr  <= 1'b0;
      end else begin
         o_wr <= 1'b0;
         case (state)
            EMIT_MERGE: begin
               if (issue.valid) begin
                  // Nothing is written for a first tuple or an empty pair of runs.
                  o_wr <= !issue.first;
                  if (issue.flush) begin
                     state <= EMIT_TERM;
                  end
               end
            end
            EMIT_TERM: begin
               o_wr  <= 1'b1;
               state <= EMIT_MERGE;
            end
            default: state <= EMIT_MERGE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == EMIT_TERM) begin
         o_wr_tuple <= '0;
      end else if (issue.valid) begin
         if (issue.flush) begin
            o_wr_tuple <= carry;
         end else if (issue.first) begin
            carry <= issue.tuple;
         end else begin
            o_wr_tuple <= merged_low;
            carry      <= merged_high;
         end
      end
   end

endmodule

// File: hdl/merge_result.sv
`timescale 1ns/10ps

module merge_result #(
   parameter int P_DATA_W  = merge_pkg::DATA_W,
   parameter int P_TUPLE_E = merge_pkg::TUPLE_E
) (
   input  logic                          i_clk,
   input  logic                          i_rst_n,
   input  logic                          i_wr,
   input  logic [P_TUPLE_E*P_DATA_W-1:0] i_wr_tuple,
   input  logic                          i_out_ready,
   output logic                          o_room,
   output logic                          o_out_write,
   output logic [P_TUPLE_E*P_DATA_W-1:0] o_out_data
);

   localparam int DEPTH    = 8;
   localparam int ROOM_MIN = 4;
   localparam int PTR_W    = $clog2(DEPTH);

   logic [P_TUPLE_E*P_DATA_W-1:0] mem [DEPTH];
   logic [PTR_W-1:0]              wr_ptr;
   logic [PTR_W-1:0]              rd_ptr;
   logic [PTR_W:0]                count;
   logic                          ready_q;
   logic                          rd_en;

   assign rd_en       = ready_q && (count != '0);
   assign o_out_write = rd_en;
   assign o_out_data  = mem[rd_ptr];

   // Enough free slots for every tuple that may still be in flight.
   assign o_room = (count <= (PTR_W+1)'(DEPTH - ROOM_MIN));

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ready_q <= 1'b0;
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
      end else begin
         ready_q <= i_out_ready;
         if (i_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({i_wr, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_wr) begin
         mem[wr_ptr] <= i_wr_tuple;
      end
   end

endmodule

// File: hdl/tuple_merger.sv
`timescale 1ns/10ps

module tuple_merger #(
   parameter int P_DATA_W  = merge_pkg::DATA_W,
   parameter int P_KEY_W   = merge_pkg::KEY_W,
   parameter int P_TUPLE_E = merge_pkg::TUPLE_E
) (
   input  logic                          i_clk,
   input  logic                          i_rst_n,
   input  logic [P_TUPLE_E*P_DATA_W-1:0] i_a_data,
   input  logic [P_TUPLE_E*P_DATA_W-1:0] i_b_data,
   input  logic                          i_a_empty,
   input  logic                          i_b_empty,
   output logic                          o_a_read,
   output logic                          o_b_read,
   input  logic                          i_out_ready,
   output logic                          o_out_write,
   output logic [P_TUPLE_E*P_DATA_W-1:0] o_out_data
);

   logic                          room;
   logic                          wr;
   logic [P_TUPLE_E*P_DATA_W-1:0] wr_tuple;

   merge_issue_if #(
      .P_DATA_W  (P_DATA_W),
      .P_TUPLE_E (P_TUPLE_E)
   ) issue_if ();

   // Decode.
   merge_select #(
      .P_DATA_W  (P_DATA_W),
      .P_KEY_W   (P_KEY_W),
      .P_TUPLE_E (P_TUPLE_E)
   ) select0 (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_a_data  (i_a_data),
      .i_b_data  (i_b_data),
      .i_a_empty (i_a_empty),
      .i_b_empty (i_b_empty),
      .i_room    (room),
      .o_a_read  (o_a_read),
      .o_b_read  (o_b_read),
      .issue     (issue_if.sel)
   );

   // Execute.
   bitonic_merge #(
      .P_DATA_W  (P_DATA_W),
      .P_KEY_W   (P_KEY_W),
      .P_TUPLE_E (P_TUPLE_E)
   ) merge0 (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .issue      (issue_if.net),
      .o_wr       (wr),
      .o_wr_tuple (wr_tuple)
   );

   // Result buffering.
   merge_result #(
      .P_DATA_W  (P_DATA_W),
      .P_TUPLE_E (P_TUPLE_E)
   ) result0 (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_wr        (wr),
      .i_wr_tuple  (wr_tuple),
      .i_out_ready (i_out_ready),
      .o_room      (room),
      .o_out_write (o_out_write),
      .o_out_data  (o_out_data)
   );

endmodule

// File: test/merge_checker.sv
`timescale 1ns/10ps

module merge_checker (
   input  logic              i_clk,
   input  logic              i_rst_n,
   input  logic              i_a_empty,
   input  logic              i_a_read,
   input  logic              i_b_empty,
   input  logic              i_b_read,
   input  logic              i_out_ready,
   input  logic              i_out_write,
   input  merge_pkg::tuple_t i_out_data,
   input  logic              i_exp_push,
   input  merge_pkg::tuple_t i_exp_tuple,
   output int                o_checked,
   output int                o_errors
);
   import merge_pkg::*;

   tuple_t exp_q[$];
   logic   ready_seen;

   always @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_checked = 0;
         o_errors  = 0;
         ready_seen = 1'b0;
         exp_q.delete();
      end else begin
         if (i_exp_push) begin
            exp_q.push_back(i_exp_tuple);
         end
         // A pop is only legal while the input shows a head.
         if (i_a_read && i_a_empty) begin
            $display("input A was popped while empty at %0t", $time);
            o_errors++;
         end
         if (i_b_read && i_b_empty) begin
            $display("input B was popped while empty at %0t", $time);
            o_errors++;
         end
         // The sink takes a tuple only one cycle after it showed ready.
         if (i_out_write && !ready_seen) begin
            $display("output was written while ready was low at %0t", $time);
            o_errors++;
         end
         ready_seen = i_out_ready;
         if (i_out_write) begin
            if (exp_q.size() == 0) begin
               $display("output tuple %h was written with none expected", i_out_data);
               o_errors++;
            end else begin
               if (i_out_data !== exp_q[0]) begin
                  $display("error o_out_data expected %h actual %h", exp_q[0], i_out_data);
                  o_errors++;
               end
               exp_q.delete(0);
               o_checked++;
            end
         end
      end
   end

endmodule

// File: test/tb_tuple_merger.sv
`timescale 1ns/10ps

module tb_tuple_merger;
   import merge_pkg::*;

   localparam int E = TUPLE_E;
   // Input tuples of all pairs plus one terminator per run.
   localparam int TUPLE_TOTAL = (6+6) + (1+8) + (0+8) + (6+5) + (5+6) + (2+3) + (4+1) + (3+3)
                                + 2*8;
   localparam int WATCHDOG_CYCLES = 40 * TUPLE_TOTAL;

   logic        i_clk;
   logic        i_rst_n;
   tuple_t      i_a_data;
   tuple_t      i_b_data;
   logic        i_a_empty;
   logic        i_b_empty;
   logic        o_a_read;
   logic        o_b_read;
   logic        i_out_ready;
   logic        o_out_write;
   tuple_t      o_out_data;
   logic        exp_push;
   tuple_t      exp_tuple;
   int          checked;
   int          errors;
   tuple_t      qa[$];
   tuple_t      qb[$];
   tuple_t      exp_new[$];
   record_t     rec_a[$];
   record_t     rec_b[$];
   int unsigned seed = 32'd67290;
   logic        hold_inputs;
   logic        drop_mode;
   logic        gap_mode;
   int          ready_hold;
   int          tests_run;
   int          tests_failed;

   tuple_merger dut0 (.*);

   merge_checker chk0 (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_a_empty   (i_a_empty),
      .i_a_read    (o_a_read),
      .i_b_empty   (i_b_empty),
      .i_b_read    (o_b_read),
      .i_out_ready (i_out_ready),
      .i_out_write (o_out_write),
      .i_out_data  (o_out_data),
      .i_exp_push  (exp_push),
      .i_exp_tuple (exp_tuple),
      .o_checked   (checked),
      .o_errors    (errors)
   );

   always #5 i_clk = ~i_clk;

   function automatic int unsigned lcg_next();
      seed = seed * 32'd1103515245 + 32'd12345;
      return seed >> 8;
   endfunction

   // Expected output: all records of the pair merged by key, then a terminator.
   function automatic void merge_reference();
      int      ia = 0;
      int      ib = 0;
      int      n = 0;
      tuple_t  tup = '0;
      record_t rec;
      while (ia < rec_a.size() || ib < rec_b.size()) begin
         if (ib >= rec_b.size() ||
             (ia < rec_a.size() && rec_a[ia][KEY_W-1:0] < rec_b[ib][KEY_W-1:0])) begin
            rec = rec_a[ia];
            ia++;
         end else begin
            rec = rec_b[ib];
            ib++;
         end
         tup[n*DATA_W +: DATA_W] = rec;
         n++;
         if (n == E) begin
            exp_new.push_back(tup);
            n = 0;
         end
      end
      exp_new.push_back('0);
   endfunction

   // Rising distinct keys dealt out at random to runs of na and nb tuples.
   task automatic make_pair(input int na, input int nb);
      int      ra;
      int      rb;
      int      key;
      record_t rec;
      tuple_t  tup;
      hold_inputs = 1'b1;
      ra = na * E;
      rb = nb * E;
      key = 0;
      rec_a.delete();
      rec_b.delete();
      while (ra + rb > 0) begin
         key = key + 1 + int'(lcg_next() % 40);
         rec = (record_t'(lcg_next()) << KEY_W) | record_t'(key);
         if (ra > 0 && (rb == 0 || (lcg_next() % 2) == 1)) begin
            rec_a.push_back(rec);
            ra--;
         end else begin
            rec_b.push_back(rec);
            rb--;
         end
      end
      for (int t = 0; t < na; t++) begin
         for (int i = 0; i < E; i++) tup[i*DATA_W +: DATA_W] = rec_a[t*E + i];
         qa.push_back(tup);
      end
      for (int t = 0; t < nb; t++) begin
         for (int i = 0; i < E; i++) tup[i*DATA_W +: DATA_W] = rec_b[t*E + i];
         qb.push_back(tup);
      end
      qa.push_back('0);
      qb.push_back('0);
      merge_reference();
   endtask

   task automatic finish_test(input string name);
      int target;
      int errs_before;
      errs_before = errors;
      target = checked + exp_new.size();
      while (exp_new.size() > 0) begin
         exp_push = 1'b1;
         exp_tuple = exp_new.pop_front();
         @(negedge i_clk);
      end
      exp_push = 1'b0;
      hold_inputs = 1'b0;
      while (checked < target) @(negedge i_clk);
      // A few idle cycles so that any extra output is caught.
      repeat (8) @(negedge i_clk);
      tests_run++;
      if (errors == errs_before) begin
         $display("test %0d %s passed", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s failed with %0d errors", tests_run, name, errors - errs_before);
      end
      drop_mode = 1'b0;
      gap_mode = 1'b0;
   endtask

   // Inputs behave like first-word-fall-through FIFOs.
   always @(negedge i_clk) begin
      i_a_data  = (qa.size() > 0) ? qa[0] : '0;
      i_b_data  = (qb.size() > 0) ? qb[0] : '0;
      i_a_empty = hold_inputs || (qa.size() == 0) || (gap_mode && (lcg_next() % 3) == 0);
      i_b_empty = hold_inputs || (qb.size() == 0) || (gap_mode && (lcg_next() % 3) == 0);
      if (ready_hold > 0) begin
         ready_hold--;
         i_out_ready = 1'b0;
      end else if (drop_mode && (lcg_next() % 8) == 0) begin
         ready_hold = int'(lcg_next() % 20);
         i_out_ready = 1'b0;
      end else begin
         i_out_ready = 1'b1;
      end
   end

   always @(posedge i_clk) begin
      if (o_a_read && qa.size() > 0) qa.delete(0);
      if (o_b_read && qb.size() > 0) qb.delete(0);
   end

   initial begin
      i_clk = 1'b0;
      i_rst_n = 1'b0;
      i_a_data = '0;
      i_b_data = '0;
      i_a_empty = 1'b1;
      i_b_empty = 1'b1;
      i_out_ready = 1'b1;
      exp_push = 1'b0;
      exp_tuple = '0;
      hold_inputs = 1'b1;
      drop_mode = 1'b0;
      gap_mode = 1'b0;
      ready_hold = 0;
      tests_run = 0;
      tests_failed = 0;
      repeat (3) @(posedge i_clk);
      @(negedge i_clk);
      i_rst_n = 1'b1;
      make_pair(6, 6);
      finish_test("two runs of 6 tuples");
      make_pair(1, 8);
      make_pair(0, 8);
      finish_test("uneven runs and an empty run");
      drop_mode = 1'b1;
      make_pair(6, 5);
      finish_test("random ready drops");
      gap_mode = 1'b1;
      make_pair(5, 6);
      finish_test("random input gaps");
      make_pair(2, 3);
      make_pair(4, 1);
      make_pair(3, 3);
      finish_test("three back-to-back run pairs");
      $display("%0d tests run, %0d failed, %0d tuples checked, %0d errors",
               tests_run, tests_failed, checked, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * 10);
      $display("watchdog expired after %0d cycles with tests still running", WATCHDOG_CYCLES);
      $display("Finished with errors");
      $finish;
   end

endmodule

// File: verilog.f
hdl/merge_pkg.sv
hdl/merge_issue_if.sv
hdl/merge_select.sv
hdl/bitonic_merge.sv
hdl/merge_result.sv
hdl/tuple_merger.sv
test/merge_checker.sv
test/tb_tuple_merger.sv

// File: run_sim.sh
#!/bin/bash
# Builds the tuple merger testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_tuple_merger \
   -o sim_tuple_merger > build.log 2>&1 \
   && ./obj_dir/sim_tuple_merger > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }

cat sim.log
grep -q "Finished with errors" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
